// ==== cpuPkg.sv ====
package cpuPkg;

  ////////////////////
  // Widths
  ////////////////////
  localparam int instW   = 16;
  localparam int dataW   = 16;
  localparam int regIdxW = 3;

  typedef logic [regIdxW-1:0] regIdxT;
  typedef logic [dataW-1:0]   dataT;
  typedef logic [instW-1:0]   instT;

  // Kept opcodes only, anything else decodes as NOP
  typedef enum logic [4:0] {
    opNop   = 5'b00000,
    opHalt  = 5'b00001,
    opLoad  = 5'b00010,
    opStore = 5'b00011,
    opAdd   = 5'b10000,
    opAddi  = 5'b10001,
    opSub   = 5'b10011,
    opSubi  = 5'b10100,
    opInc   = 5'b10110,
    opLdil  = 5'b10111,
    opLdih  = 5'b11000,
    opXor   = 5'b11001,
    opAnd   = 5'b11010,
    opOr    = 5'b11011,
    opSll   = 5'b11100,
    opSla   = 5'b11101,
    opSrl   = 5'b11110,
    opSra   = 5'b11111
  } opcodeT;

  typedef enum logic [3:0] {
    aluAdd, aluSub, aluInc,
    aluXor, aluAnd, aluOr,
    aluSll, aluSla, aluSrl, aluSra,
    aluPassB  // immediate loads
  } aluOpT;

  ////////////////////
  // Instruction fields
  ////////////////////
  function automatic opcodeT opcodeOf(input instT i);
    return opcodeT'(i[15:11]);
  endfunction

  function automatic regIdxT r1Of(input instT i);
    return i[10:8];
  endfunction

  function automatic regIdxT r2Of(input instT i);
    return i[6:4];
  endfunction

  function automatic regIdxT r3Of(input instT i);
    return i[2:0];
  endfunction

  function automatic logic [3:0] val2Of(input instT i);
    return i[7:4];
  endfunction

  function automatic logic [3:0] val3Of(input instT i);
    return i[3:0];
  endfunction

endpackage

// ==== fetchStage.sv ====
`timescale 1ns/1ps

module fetchStage #(
  parameter int pcW = 8
) (
  input  logic               CLK,
  input  logic               RST,
  input  logic               en,
  input  logic               start,
  input  logic               stall,
  input  logic               haltSeen,
  input  logic               wbHalt,
  input  cpuPkg::instT       inst,
  output logic [pcW-1:0]     instAddr,
  output cpuPkg::instT       idInst,
  output logic               run
);

  typedef enum logic {sIdle, sExec} stateT;

  localparam cpuPkg::instT nopInst = {cpuPkg::opNop, 11'b0};

  stateT          state;
  stateT          nextState;
  logic [pcW-1:0] pc;

  assign run      = (state == sExec);
  assign instAddr = pc;

  ////////////////////
  // Run / idle control
  ////////////////////
  always_comb begin
    nextState = state;
    case (state)
      sIdle: begin
        if (en && start) begin
          nextState = sExec;
        end
      end
      sExec: begin
        // Pause on enable drop, stop once halt retires
        if (!en || wbHalt) begin
          nextState = sIdle;
        end
      end
      default: nextState = sIdle;
    endcase
  end

  ////////////////////
  // Program counter and fetch register
  ////////////////////
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state  <= sIdle;
      pc     <= '0;
      idInst <= nopInst;
    end else begin
      state <= nextState;
      if (run) begin
        if (!stall && !haltSeen) begin
          pc <= pc + 1'b1;
        end
        if (haltSeen) begin
          idInst <= nopInst;  // Nothing past HALT
        end else if (!stall) begin
          idInst <= inst;
        end
      end
    end
  end

endmodule

// ==== decodeStage.sv ====
`timescale 1ns/1ps

module decodeStage (
  input  logic            CLK,
  input  logic            RST,
  input  logic            run,
  input  cpuPkg::instT    idInst,
  input  cpuPkg::dataT    rd1,
  input  cpuPkg::dataT    rd2,
  input  cpuPkg::dataT    rd3,
  output cpuPkg::regIdxT  rs1,
  output cpuPkg::regIdxT  rs2,
  output cpuPkg::regIdxT  rs3,
  input  cpuPkg::dataT    aluOut,
  input  cpuPkg::dataT    mrResult,
  input  cpuPkg::dataT    dataIn,
  input  cpuPkg::dataT    wbData,
  input  cpuPkg::regIdxT  mrDest,
  input  cpuPkg::regIdxT  wbDest,
  input  logic            mrWrites,
  input  logic            mrLoad,
  input  logic            wbWrites,
  output logic            stall,
  output logic            haltSeen,
  output cpuPkg::aluOpT   exOp,
  output cpuPkg::dataT    exA,
  output cpuPkg::dataT    exB,
  output cpuPkg::dataT    exStoreData,
  output cpuPkg::regIdxT  exDest,
  output logic            exWrites,
  output logic            exLoad,
  output logic            exStore,
  output logic            exHalt
);

  cpuPkg::aluOpT dOp;
  cpuPkg::dataT  dA, dB, dSd;
  cpuPkg::dataT  v1, v2, v3;
  logic          dWrites, dLoad, dStore, dHalt;
  logic          useR1, useR2, useR3;
  logic          haltReg;
  logic [7:0]    imm;

  assign rs1 = cpuPkg::r1Of(idInst);
  assign rs2 = cpuPkg::r2Of(idInst);
  assign rs3 = cpuPkg::r3Of(idInst);
  assign imm = {cpuPkg::val2Of(idInst), cpuPkg::val3Of(idInst)};

  // Newest producer wins
  function automatic cpuPkg::dataT fwd(input cpuPkg::regIdxT src, input cpuPkg::dataT rfVal);
    if (exWrites && !exLoad && exDest == src) begin
      return aluOut;
    end else if (mrWrites && mrDest == src) begin
      return mrLoad ? dataIn : mrResult;
    end else if (wbWrites && wbDest == src) begin
      return wbData;  // Covers same-cycle register write
    end
    return rfVal;
  endfunction

  assign v1 = fwd(rs1, rd1);
  assign v2 = fwd(rs2, rd2);
  assign v3 = fwd(rs3, rd3);

  ////////////////////
  // Opcode decode
  ////////////////////
  always_comb begin
    dOp = cpuPkg::aluAdd;
    dA = v2;
    dB = v3;
    dSd = v1;
    {dWrites, dLoad, dStore, dHalt} = 4'b0000;
    {useR1, useR2, useR3} = 3'b000;
    case (cpuPkg::opcodeOf(idInst))
      cpuPkg::opHalt: dHalt = 1'b1;
      cpuPkg::opLoad, cpuPkg::opStore: begin
        dB = cpuPkg::dataT'(cpuPkg::val3Of(idInst));  // Base plus offset
        useR2 = 1'b1;
        dLoad = (cpuPkg::opcodeOf(idInst) == cpuPkg::opLoad);
        dStore = !dLoad;
        dWrites = dLoad;
        useR1 = dStore;  // Store data
      end
      cpuPkg::opAddi, cpuPkg::opSubi: begin
        dOp = (cpuPkg::opcodeOf(idInst) == cpuPkg::opAddi) ? cpuPkg::aluAdd : cpuPkg::aluSub;
        dA = v1;
        dB = cpuPkg::dataT'(imm);
        {useR1, dWrites} = 2'b11;
      end
      cpuPkg::opInc: {dOp, useR2, dWrites} = {cpuPkg::aluInc, 2'b11};
      cpuPkg::opLdil: begin
        dOp = cpuPkg::aluPassB;
        dB = cpuPkg::dataT'(imm);
        dWrites = 1'b1;
      end
      cpuPkg::opLdih: begin
        dOp = cpuPkg::aluPassB;
        dB = {imm, 8'h00};
        dWrites = 1'b1;
      end
      cpuPkg::opAdd: {dOp, useR2, useR3, dWrites} = {cpuPkg::aluAdd, 3'b111};
      cpuPkg::opSub: {dOp, useR2, useR3, dWrites} = {cpuPkg::aluSub, 3'b111};
      cpuPkg::opXor: {dOp, useR2, useR3, dWrites} = {cpuPkg::aluXor, 3'b111};
      cpuPkg::opAnd: {dOp, useR2, useR3, dWrites} = {cpuPkg::aluAnd, 3'b111};
      cpuPkg::opOr:  {dOp, useR2, useR3, dWrites} = {cpuPkg::aluOr, 3'b111};
      cpuPkg::opSll: {dOp, useR2, useR3, dWrites} = {cpuPkg::aluSll, 3'b111};
      cpuPkg::opSla: {dOp, useR2, useR3, dWrites} = {cpuPkg::aluSla, 3'b111};
      cpuPkg::opSrl: {dOp, useR2, useR3, dWrites} = {cpuPkg::aluSrl, 3'b111};
      cpuPkg::opSra: {dOp, useR2, useR3, dWrites} = {cpuPkg::aluSra, 3'b111};
      default: ;  // Unsupported opcodes act as NOP
    endcase
  end

  // Load in execute feeding a source register here
  assign stall = exLoad && ((useR1 && exDest == rs1) || (useR2 && exDest == rs2) ||
                            (useR3 && exDest == rs3));
  assign haltSeen = haltReg || dHalt;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      exOp <= cpuPkg::aluAdd;
      {exWrites, exLoad, exStore, exHalt} <= 4'b0000;
      haltReg <= 1'b0;
    end else if (run) begin
      exOp <= dOp;
      exWrites <= dWrites && !stall;  // Bubble on interlock
      exLoad <= dLoad && !stall;
      exStore <= dStore && !stall;
      exHalt <= dHalt;
      if (dHalt) begin
        haltReg <= 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (run) begin
      exA <= dA;
      exB <= dB;
      exStoreData <= dSd;
      exDest <= rs1;  // Always r1
    end
  end

endmodule

// ==== regFile.sv ====
`timescale 1ns/1ps

module regFile (
  input  logic            CLK,
  input  logic            RST,
  input  logic            we,
  input  cpuPkg::regIdxT  wa,
  input  cpuPkg::regIdxT  ra1,
  input  cpuPkg::regIdxT  ra2,
  input  cpuPkg::regIdxT  ra3,
  input  cpuPkg::dataT    wd,
  output cpuPkg::dataT    q1,
  output cpuPkg::dataT    q2,
  output cpuPkg::dataT    q3
);

  cpuPkg::dataT regs [8];

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int i = 0; i < 8; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[wa] <= wd;
    end
  end

  // Reads see the value before this cycle's write
  assign q1 = regs[ra1];
  assign q2 = regs[ra2];
  assign q3 = regs[ra3];

endmodule

// ==== executeStage.sv ====
`timescale 1ns/1ps

module executeStage #(
  parameter int pcW = 8
) (
  input  logic            CLK,
  input  logic            RST,
  input  logic            run,
  input  cpuPkg::aluOpT   exOp,
  input  cpuPkg::dataT    exA,
  input  cpuPkg::dataT    exB,
  input  cpuPkg::dataT    exStoreData,
  input  cpuPkg::regIdxT  exDest,
  input  logic            exWrites,
  input  logic            exLoad,
  input  logic            exStore,
  input  logic            exHalt,
  output cpuPkg::dataT    aluOut,
  output cpuPkg::dataT    mrResult,
  output cpuPkg::regIdxT  mrDest,
  output logic            mrWrites,
  output logic            mrLoad,
  output logic            mrHalt,
  output logic [pcW-1:0]  dataAddr,
  output logic            dataWe,
  output cpuPkg::dataT    dataOut
);

  cpuPkg::dataT mrStoreData;
  logic         mrStore;
  logic [3:0]   shamt;

  assign shamt = exB[3:0];

  ////////////////////
  // ALU
  ////////////////////
  always_comb begin
    case (exOp)
      cpuPkg::aluAdd:   aluOut = exA + exB;  // Also load/store address
      cpuPkg::aluSub:   aluOut = exA - exB;
      cpuPkg::aluInc:   aluOut = exA + 16'd1;
      cpuPkg::aluXor:   aluOut = exA ^ exB;
      cpuPkg::aluAnd:   aluOut = exA & exB;
      cpuPkg::aluOr:    aluOut = exA | exB;
      cpuPkg::aluSll,
      cpuPkg::aluSla:   aluOut = exA << shamt;
      cpuPkg::aluSrl:   aluOut = exA >> shamt;
      cpuPkg::aluSra:   aluOut = cpuPkg::dataT'($signed(exA) >>> shamt);
      cpuPkg::aluPassB: aluOut = exB;
      default:          aluOut = exB;
    endcase
  end

  ////////////////////
  // Execute to memory registers
  ////////////////////
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      {mrWrites, mrLoad, mrStore, mrHalt} <= 4'b0000;
    end else if (run) begin
      mrWrites <= exWrites;
      mrLoad <= exLoad;
      mrStore <= exStore;
      mrHalt <= exHalt;
    end
  end

  always_ff @(posedge CLK) begin
    if (run) begin
      mrResult <= aluOut;
      mrDest <= exDest;
      mrStoreData <= exStoreData;
    end
  end

  // Data memory port
  assign dataAddr = mrResult[pcW-1:0];
  assign dataWe   = mrStore && run;  // No writes while paused
  assign dataOut  = mrStoreData;

endmodule

// ==== memAccessStage.sv ====
`timescale 1ns/1ps

module memAccessStage (
  input  logic            CLK,
  input  logic            RST,
  input  logic            run,
  input  cpuPkg::dataT    mrResult,
  input  cpuPkg::dataT    dataIn,
  input  cpuPkg::regIdxT  mrDest,
  input  logic            mrWrites,
  input  logic            mrLoad,
  input  logic            mrHalt,
  output cpuPkg::dataT    wbData,
  output cpuPkg::regIdxT  wbDest,
  output logic            wbWrites,
  output logic            wbHalt
);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wbWrites <= 1'b0;
      wbHalt <= 1'b0;
    end else if (run) begin
      wbWrites <= mrWrites;
      wbHalt <= mrHalt;  // Ends the run one cycle on
    end
  end

  // Loaded word or ALU result
  always_ff @(posedge CLK) begin
    if (run) begin
      wbData <= mrLoad ? dataIn : mrResult;
      wbDest <= mrDest;
    end
  end

endmodule

// ==== cpuCore.sv ====
`timescale 1ns/1ps

module cpuCore #(
  parameter int pcW = 8
) (
  input  logic            CLK,
  input  logic            RST,
  input  logic            en,
  input  logic            start,
  output logic [pcW-1:0]  instAddr,
  input  cpuPkg::instT    inst,
  output logic [pcW-1:0]  dataAddr,
  output logic            dataWe,
  output cpuPkg::dataT    dataOut,
  input  cpuPkg::dataT    dataIn,
  output logic            running
);

  logic            run, stall, haltSeen;
  cpuPkg::instT    idInst;
  cpuPkg::regIdxT  rs1, rs2, rs3;
  cpuPkg::dataT    rd1, rd2, rd3;
  cpuPkg::aluOpT   exOp;
  cpuPkg::dataT    exA, exB, exStoreData;
  cpuPkg::regIdxT  exDest;
  logic            exWrites, exLoad, exStore, exHalt;
  cpuPkg::dataT    aluOut, mrResult, wbData;
  cpuPkg::regIdxT  mrDest, wbDest;
  logic            mrWrites, mrLoad, mrHalt;
  logic            wbWrites, wbHalt;

  assign running = run;

  fetchStage #(.pcW(pcW)) uFetch (
    .CLK, .RST, .en, .start, .stall, .haltSeen, .wbHalt,
    .inst, .instAddr, .idInst, .run
  );

  decodeStage uDecode (
    .CLK, .RST, .run, .idInst, .rd1, .rd2, .rd3, .rs1, .rs2, .rs3,
    .aluOut, .mrResult, .dataIn, .wbData, .mrDest, .wbDest,
    .mrWrites, .mrLoad, .wbWrites, .stall, .haltSeen,
    .exOp, .exA, .exB, .exStoreData, .exDest,
    .exWrites, .exLoad, .exStore, .exHalt
  );

  // Write-back port
  regFile uRegs (
    .CLK, .RST, .we(wbWrites && run), .wa(wbDest),
    .ra1(rs1), .ra2(rs2), .ra3(rs3), .wd(wbData),
    .q1(rd1), .q2(rd2), .q3(rd3)
  );

  executeStage #(.pcW(pcW)) uExecute (
    .CLK, .RST, .run, .exOp, .exA, .exB, .exStoreData, .exDest,
    .exWrites, .exLoad, .exStore, .exHalt, .aluOut, .mrResult, .mrDest,
    .mrWrites, .mrLoad, .mrHalt, .dataAddr, .dataWe, .dataOut
  );

  memAccessStage uMemAccess (
    .CLK, .RST, .run, .mrResult, .dataIn, .mrDest, .mrWrites, .mrLoad,
    .mrHalt, .wbData, .wbDest, .wbWrites, .wbHalt
  );

endmodule

// ==== cpuCore_props.sv ====
`timescale 1ns/1ps

module cpuCoreProps #(
  parameter int pcW = 8
) (
  input logic           CLK,
  input logic           RST,
  input logic           en,
  input logic           start,
  input logic           running,
  input logic [pcW-1:0] instAddr,
  input logic [pcW-1:0] dataAddr,
  input logic           dataWe,
  input cpuPkg::dataT   dataOut,
  input logic           wbHalt
);

  int failCount = 0;  // Failed assertion count

  ////////////////////
  // Reset and idle
  ////////////////////
  resetIdle: assert property (@(posedge CLK)
    RST |-> !running && !dataWe && instAddr == '0)
    else begin
      failCount = failCount + 1;
      $error("core active or PC nonzero during reset");
    end

  staysIdle: assert property (@(posedge CLK) disable iff (RST)
    !running && !(en && start) |=> !running)
    else begin
      failCount = failCount + 1;
      $error("core started without en and start");
    end

  // PC frozen whenever the core is not running
  pcHolds: assert property (@(posedge CLK) disable iff (RST)
    !running |=> $stable(instAddr))
    else begin
      failCount = failCount + 1;
      $error("instruction address moved while idle");
    end

  pauseStops: assert property (@(posedge CLK) disable iff (RST)
    running && !en |=> !running)
    else begin
      failCount = failCount + 1;
      $error("core kept running after en dropped");
    end

  ////////////////////
  // Halt and stores
  ////////////////////
  haltStops: assert property (@(posedge CLK) disable iff (RST)
    running && wbHalt |=> !running)
    else begin
      failCount = failCount + 1;
      $error("core kept running after HALT retired");
    end

  noStoreAfterHalt: assert property (@(posedge CLK) disable iff (RST)
    wbHalt |-> !dataWe)
    else begin
      failCount = failCount + 1;
      $error("store issued behind a retired HALT");
    end

  storeClean: assert property (@(posedge CLK) disable iff (RST)
    dataWe |-> !$isunknown({dataAddr, dataOut}))
    else begin
      failCount = failCount + 1;
      $error("store with unknown address or data");
    end

endmodule

bind cpuCore cpuCoreProps #(.pcW(pcW)) props (
  .CLK(CLK),
  .RST(RST),
  .en(en),
  .start(start),
  .running(running),
  .instAddr(instAddr),
  .dataAddr(dataAddr),
  .dataWe(dataWe),
  .dataOut(dataOut),
  .wbHalt(wbHalt)
);

// ==== tbCpu.sv ====
`timescale 1ns/1ps

module tbCpu;

  logic         CLK;
  logic         RST;
  logic         en;
  logic         start;
  logic [7:0]   instAddr;
  logic [7:0]   dataAddr;
  logic         dataWe;
  logic         running;
  cpuPkg::instT inst;
  cpuPkg::dataT dataOut;
  cpuPkg::dataT dataIn;

  cpuPkg::instT rom [256];
  cpuPkg::dataT ram [256];
  cpuPkg::dataT modelMem [256];  // Model's view of the data RAM
  cpuPkg::instT prog [$];
  logic [7:0]   expAddr [$];
  cpuPkg::dataT expData [$];
  logic [31:0]  seed;
  string        testName;
  int           storeCount;

  cpuCore #(.pcW(8)) DUT (
    .CLK(CLK), .RST(RST), .en(en), .start(start), .instAddr(instAddr), .inst(inst),
    .dataAddr(dataAddr), .dataWe(dataWe), .dataOut(dataOut), .dataIn(dataIn),
    .running(running)
  );

  assign inst   = rom[instAddr];  // Both memories combinational
  assign dataIn = ram[dataAddr];

  always #10 CLK = ~CLK;

  task automatic reportFailure(input string msg);
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  function automatic logic [31:0] nextRandom();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [7:0] rnd8();
    return 8'(nextRandom() >> 16);
  endfunction

  ////////////////////
  // Store monitor
  ////////////////////
  always @(negedge CLK) begin
    if (dataWe) begin
      assert (expAddr.size() != 0)
        else reportFailure($sformatf("%s: store to %h that the model does not make",
                                     testName, dataAddr));
      if (expAddr.size() != 0) begin
        assert (dataAddr == expAddr[0])
          else reportFailure($sformatf("CHECK FAILED %s store address: expected %h, actual %h",
                                       testName, expAddr[0], dataAddr));
        assert (dataOut == expData[0])
          else reportFailure($sformatf("CHECK FAILED %s store data: expected %h, actual %h",
                                       testName, expData[0], dataOut));
        ram[dataAddr] = dataOut;  // RAM write port
        void'(expAddr.pop_front());
        void'(expData.pop_front());
        storeCount++;
      end
    end
  end

  always @(negedge CLK) begin
    if (DUT.props.failCount != 0) begin
      reportFailure("a bound assertion on the core failed");
    end
  end

  ////////////////////
  // Instruction encoders
  ////////////////////
  function automatic cpuPkg::instT regOp(cpuPkg::opcodeT op, int d, int s2, int s3);
    return {op, 3'(d), 1'b0, 3'(s2), 1'b0, 3'(s3)};
  endfunction

  function automatic cpuPkg::instT immOp(cpuPkg::opcodeT op, int d, logic [7:0] v);
    return {op, 3'(d), v};
  endfunction

  function automatic cpuPkg::instT memOp(cpuPkg::opcodeT op, int d, int base, int off);
    return {op, 3'(d), 1'b0, 3'(base), 4'(off)};
  endfunction

  // Sequential ISA model, queues the expected stores
  task automatic modelProgram();
    cpuPkg::dataT r [8];
    cpuPkg::dataT a;
    cpuPkg::dataT b;
    cpuPkg::instT i;
    logic [7:0]   addr;
    int           pc;
    pc = 0;
    expAddr.delete();
    expData.delete();
    for (int k = 0; k < 8; k++) begin
      r[k] = '0;
    end
    while (pc < 256) begin
      i = rom[pc];
      pc++;
      a = r[i[6:4]];
      b = r[i[2:0]];
      addr = a[7:0] + {4'h0, i[3:0]};
      case (i[15:11])
        cpuPkg::opHalt:  pc = 256;
        cpuPkg::opLoad:  r[i[10:8]] = modelMem[addr];
        cpuPkg::opStore: begin
          modelMem[addr] = r[i[10:8]];
          expAddr.push_back(addr);
          expData.push_back(r[i[10:8]]);
        end
        cpuPkg::opAdd:  r[i[10:8]] = a + b;
        cpuPkg::opAddi: r[i[10:8]] = r[i[10:8]] + {8'h00, i[7:0]};
        cpuPkg::opSub:  r[i[10:8]] = a - b;
        cpuPkg::opSubi: r[i[10:8]] = r[i[10:8]] - {8'h00, i[7:0]};
        cpuPkg::opInc:  r[i[10:8]] = a + 16'd1;
        cpuPkg::opLdil: r[i[10:8]] = {8'h00, i[7:0]};
        cpuPkg::opLdih: r[i[10:8]] = {i[7:0], 8'h00};
        cpuPkg::opXor:  r[i[10:8]] = a ^ b;
        cpuPkg::opAnd:  r[i[10:8]] = a & b;
        cpuPkg::opOr:   r[i[10:8]] = a | b;
        cpuPkg::opSll,
        cpuPkg::opSla:  r[i[10:8]] = a << b[3:0];
        cpuPkg::opSrl:  r[i[10:8]] = a >> b[3:0];
        cpuPkg::opSra:  r[i[10:8]] = $signed(a) >>> b[3:0];
        default: ;  // Dropped opcodes
      endcase
    end
  endtask

  ////////////////////
  // Programs
  ////////////////////
  task automatic buildChain();
    prog.delete();
    prog.push_back(immOp(cpuPkg::opLdil, 1, rnd8()));
    prog.push_back(immOp(cpuPkg::opLdih, 2, rnd8()));
    prog.push_back(regOp(cpuPkg::opOr, 3, 2, 1));  // Execute and memory paths
    prog.push_back(immOp(cpuPkg::opAddi, 3, rnd8()));
    prog.push_back(regOp(cpuPkg::opAdd, 4, 3, 2));  // Write-back path on r2
    prog.push_back(regOp(cpuPkg::opSub, 5, 4, 1));
    prog.push_back(memOp(cpuPkg::opStore, 5, 0, 1));
    prog.push_back(regOp(cpuPkg::opXor, 6, 5, 4));
    prog.push_back(immOp(cpuPkg::opLdil, 7, rnd8()));  // Shift amount, low nibble
    prog.push_back(regOp(cpuPkg::opSll, 1, 6, 7));
    prog.push_back(regOp(cpuPkg::opSra, 2, 6, 7));
    prog.push_back(regOp(cpuPkg::opSrl, 3, 2, 7));
    prog.push_back(regOp(cpuPkg::opSla, 4, 1, 7));
    prog.push_back(regOp(cpuPkg::opAnd, 5, 3, 4));
    prog.push_back(regOp(cpuPkg::opInc, 6, 5, 0));
    prog.push_back(immOp(cpuPkg::opSubi, 6, rnd8()));
    prog.push_back(memOp(cpuPkg::opStore, 1, 0, 2));
    prog.push_back(memOp(cpuPkg::opStore, 2, 0, 3));
    prog.push_back(memOp(cpuPkg::opStore, 3, 4, 4));
    prog.push_back(memOp(cpuPkg::opStore, 6, 0, 5));
    prog.push_back(regOp(cpuPkg::opHalt, 0, 0, 0));
    prog.push_back(memOp(cpuPkg::opStore, 1, 0, 6));  // Must never issue
    prog.push_back(memOp(cpuPkg::opStore, 2, 0, 7));
  endtask

  task automatic buildLoadUse();
    prog.delete();
    prog.push_back(immOp(cpuPkg::opLdil, 2, rnd8()));
    prog.push_back(memOp(cpuPkg::opLoad, 1, 2, 3));
    prog.push_back(regOp(cpuPkg::opAdd, 3, 1, 1));  // Needs the interlock
    prog.push_back(memOp(cpuPkg::opStore, 3, 2, 0));
    prog.push_back(memOp(cpuPkg::opLoad, 4, 2, 5));
    prog.push_back(memOp(cpuPkg::opStore, 4, 2, 1));  // Loaded value as store data
    prog.push_back(memOp(cpuPkg::opLoad, 5, 2, 3));
    prog.push_back(memOp(cpuPkg::opLoad, 6, 5, 0));  // Loaded value as base
    prog.push_back(regOp(cpuPkg::opInc, 7, 6, 0));
    prog.push_back(memOp(cpuPkg::opStore, 7, 2, 2));
    prog.push_back(memOp(cpuPkg::opLoad, 1, 2, 0));
    prog.push_back(immOp(cpuPkg::opSubi, 1, 8'h01));
    prog.push_back(memOp(cpuPkg::opStore, 1, 2, 4));
    prog.push_back(regOp(cpuPkg::opHalt, 0, 0, 0));
    prog.push_back(memOp(cpuPkg::opStore, 7, 2, 6));
  endtask

  task automatic buildPaused();
    prog.delete();
    prog.push_back(immOp(cpuPkg::opLdil, 1, rnd8()));
    prog.push_back(immOp(cpuPkg::opLdil, 2, rnd8()));
    prog.push_back(regOp(cpuPkg::opAdd, 3, 1, 2));
    prog.push_back(memOp(cpuPkg::opStore, 3, 0, 8));
    prog.push_back(regOp(cpuPkg::opSub, 4, 3, 1));
    prog.push_back(memOp(cpuPkg::opStore, 4, 0, 9));
    prog.push_back({5'b01000, 11'h7ff});  // Old branch opcode, now a NOP
    prog.push_back(regOp(cpuPkg::opInc, 5, 4, 0));
    prog.push_back(memOp(cpuPkg::opStore, 5, 0, 10));
    prog.push_back(immOp(cpuPkg::opLdih, 6, rnd8()));
    prog.push_back(regOp(cpuPkg::opOr, 6, 6, 5));
    prog.push_back(memOp(cpuPkg::opStore, 6, 0, 11));
    prog.push_back(memOp(cpuPkg::opLoad, 7, 0, 8));
    prog.push_back(regOp(cpuPkg::opXor, 7, 7, 6));
    prog.push_back(memOp(cpuPkg::opStore, 7, 0, 12));
    prog.push_back(regOp(cpuPkg::opHalt, 0, 0, 0));
    prog.push_back(memOp(cpuPkg::opStore, 1, 0, 13));
  endtask

  ////////////////////
  // Control and waits
  ////////////////////
  task automatic resetCore();
    RST = 1'b1;
    en = 1'b0;
    start = 1'b0;
    repeat (8) @(negedge CLK);
    RST = 1'b0;
  endtask

  task automatic waitRunning(input logic level, input int limit, input string what);
    int n;
    n = 0;
    while (running !== level && n < limit) begin
      @(negedge CLK);
      n++;
    end
    assert (running === level)
      else reportFailure($sformatf("%s: timed out waiting for %s", testName, what));
  endtask

  task automatic waitStores(input int count, input int limit);
    int n;
    n = 0;
    while (storeCount < count && n < limit) begin
      @(negedge CLK);
      n++;
    end
    assert (storeCount >= count)
      else reportFailure($sformatf("%s: timed out waiting for %0d stores", testName, count));
  endtask

  task automatic startCore();
    en = 1'b1;
    start = 1'b1;
    waitRunning(1'b1, 10, "running to rise");
    start = 1'b0;  // One start edge is enough
  endtask

  task automatic runTest(input string name, input int pauseAt);
    logic [7:0] heldAddr;
    testName = name;
    for (int a = 0; a < 256; a++) begin
      rom[a] = (a < prog.size()) ? prog[a] : '0;
      ram[a] = cpuPkg::dataT'(nextRandom() >> 8);
      modelMem[a] = ram[a];
    end
    modelProgram();
    storeCount = 0;
    resetCore();
    en = 1'b1;
    start = 1'b0;
    for (int n = 0; n < 6; n++) begin
      if (n == 3) begin
        en = 1'b0;
        start = 1'b1;
      end
      @(negedge CLK);
      assert (!running && !dataWe && instAddr == 8'h00)
        else reportFailure($sformatf("%s: core left idle before en and start", name));
    end
    startCore();
    if (pauseAt > 0) begin
      waitStores(pauseAt, 300);
      en = 1'b0;
      @(negedge CLK);
      heldAddr = instAddr;
      for (int n = 0; n < 5; n++) begin
        assert (!running && !dataWe && instAddr == heldAddr)
          else reportFailure($sformatf("%s: core did not hold while paused", name));
        @(negedge CLK);
      end
      startCore();
    end
    waitRunning(1'b0, 300, "HALT to end the run");
    for (int n = 0; n < 10; n++) begin
      @(negedge CLK);
      assert (!running)
        else reportFailure($sformatf("%s: core ran again after HALT", name));
    end
    assert (expAddr.size() == 0)
      else reportFailure($sformatf("CHECK FAILED %s pending stores: expected 0, actual %0d",
                                   name, expAddr.size()));
  endtask

  initial begin
    CLK = 1'b0;
    RST = 1'b1;
    en = 1'b0;
    start = 1'b0;
    seed = 32'h8987680a;
    storeCount = 0;
    testName = "reset";
    buildChain();
    runTest("forwarding chain", 0);
    buildLoadUse();
    runTest("load-use interlock", 0);
    buildPaused();
    runTest("pause and resume", 2);
    if (DUT.props.failCount == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      reportFailure("a bound assertion on the core failed");
    end
  end

endmodule

// ==== all.f ====
cpuPkg.sv
fetchStage.sv
decodeStage.sv
regFile.sv
executeStage.sv
memAccessStage.sv
cpuCore.sv
cpuCore_props.sv
tbCpu.sv

// ==== Makefile ====
SIM    = verilator
FLAGS  = --binary --timing --assert -Wno-fatal
TOP    = tbCpu
FLIST  = all.f
OBJDIR = obj_dir
BIN    = $(OBJDIR)/V$(TOP)
LOG    = sim.log
SRCS   = $(shell cat $(FLIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJDIR)

run: $(BIN)
	-./$(BIN) +verilator+error+limit+100 > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
